// ==== filelist.f ====
logic/lq_pkg.sv
logic/lq_rr_arbiter.sv
logic/lq_alloc.sv
logic/lq_entries.sv
logic/lq_writeback.sv
logic/load_queue.sv
test/load_queue_checker.sv
test/load_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the load queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module load_queue_tb \
    -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vload_queue_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished"
exit 0

// ==== test/load_queue_tb.sv ====
`timescale 1ns/1ns

module load_queue_tb;

    localparam int total_loads = 300;
    localparam int timeout_cycles = total_loads * 40;

    logic                                            clock;
    logic                                            rst_n;
    logic                                            except;
    logic [lq_pkg::ways-1:0]                         ld_en;
    logic [lq_pkg::ways-1:0][1:0]                    ld_size;
    logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]  ld_rob_idx;
    logic [lq_pkg::ways-1:0][lq_pkg::prf_idx_w-1:0]  ld_prf_idx;
    logic [lq_pkg::ways-1:0]                         ld_is_signed;
    logic [lq_pkg::ways-1:0]                         alu_valid;
    logic [lq_pkg::ways-1:0]                         alu_is_ls;
    logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]  alu_rob_idx;
    logic [lq_pkg::ways-1:0][lq_pkg::addr_w-1:0]     alu_data;
    logic                                            dc_hit;
    logic [lq_pkg::data_w-1:0]                       dc_data;
    logic [lq_pkg::lq_size-1:0]                      mem_feedback;
    logic [lq_pkg::data_w-1:0]                       mem_data;
    logic                                            rd_en;
    logic [lq_pkg::lq_size-1:0]                      rd_gnt;
    logic [lq_pkg::tag_w-1:0]                        rd_tag;
    logic [lq_pkg::set_w-1:0]                        rd_set;
    logic [lq_pkg::offset_w-1:0]                     rd_offset;
    logic [1:0]                                      rd_size;
    logic                                            cdb_valid;
    logic [lq_pkg::data_w-1:0]                       cdb_data;
    logic [lq_pkg::prf_idx_w-1:0]                    cdb_prf_idx;
    logic [lq_pkg::rob_idx_w-1:0]                    cdb_rob_idx;
    logic [lq_pkg::count_w-1:0]                      lq_num_free_out;

    // model of each entry
    logic                          m_busy [lq_pkg::lq_size];
    logic [1:0]                    m_state [lq_pkg::lq_size];
    logic [lq_pkg::rob_idx_w-1:0]  m_rob [lq_pkg::lq_size];
    logic [lq_pkg::prf_idx_w-1:0]  m_prf [lq_pkg::lq_size];
    logic [1:0]                    m_size [lq_pkg::lq_size];
    logic                          m_signed [lq_pkg::lq_size];
    logic [lq_pkg::addr_w-1:0]     m_addr [lq_pkg::lq_size];
    logic [lq_pkg::data_w-1:0]     m_data [lq_pkg::lq_size];
    int                            m_alu_at [lq_pkg::lq_size];
    int                            m_mem_at [lq_pkg::lq_size];

    int                            cycles = 0;
    int                            loads_sent = 0;
    int                            flushes = 0;
    logic [lq_pkg::rob_idx_w-1:0]  next_rob = '0;
    logic                          flush_now;

    load_queue UUT (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        if (cycles >= timeout_cycles) begin
            $display("timeout: load queue did not drain within %0d cycles", timeout_cycles);
            $display("Done: errors found");
            $fatal(1, "simulation timeout");
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // byte and halfword loads widen to the full word
    function automatic logic [31:0] extend_load(input logic [31:0] raw, input logic [1:0] size,
                                                input logic sgn);
        lq_pkg::load_word_u w;
        logic [31:0]        fill;
        w = raw;
        if (size == lq_pkg::size_byte) begin
            fill = (sgn && w.bytes[0][7]) ? '1 : '0;
            return {fill[31:8], w.bytes[0]};
        end
        if (size == lq_pkg::size_half) begin
            fill = (sgn && w.halves[0][15]) ? '1 : '0;
            return {fill[31:16], w.halves[0]};
        end
        return raw;
    endfunction

    function automatic logic rob_live(input logic [lq_pkg::rob_idx_w-1:0] rob);
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (m_busy[i] && m_rob[i] == rob) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic model_has_loads();
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (m_busy[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // checks and stimulus for one falling edge
    task automatic run_cycle(input logic do_flush);
        int                      expect_free;
        int                      rel;
        int                      g;
        int                      low;
        int                      high;
        int                      ent;
        int                      alu_way;
        logic                    found;
        logic [31:0]             r;
        logic [lq_pkg::ways-1:0] want;
        except = do_flush;
        ld_en = '0;
        alu_valid = '0;
        alu_is_ls = '0;
        mem_feedback = '0;
        r = $urandom();
        dc_hit = r[0];
        dc_data = $urandom();
        mem_data = $urandom();
        for (int w = 0; w < lq_pkg::ways; w++) begin
            r = $urandom();
            alu_rob_idx[w] = r[lq_pkg::rob_idx_w-1:0];
            alu_data[w] = r[31 -: lq_pkg::addr_w];
        end

        expect_free = 0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (!m_busy[i]) begin
                expect_free++;
            end
        end
        if (expect_free < lq_pkg::ways) begin
            expect_free = 0;
        end
        check_value("free_count", expect_free, lq_num_free_out);

        rel = -1;
        if (cdb_valid) begin
            for (int i = 0; i < lq_pkg::lq_size; i++) begin
                if (m_busy[i] && m_state[i] == lq_pkg::st_done && m_rob[i] == cdb_rob_idx) begin
                    rel = i;
                end
            end
            check_value("cdb_known_load", 1, rel >= 0);
            if (rel >= 0) begin
                check_value("cdb_prf_idx", m_prf[rel], cdb_prf_idx);
                check_value("cdb_data", extend_load(m_data[rel], m_size[rel], m_signed[rel]),
                            cdb_data);
            end
        end

        if (rd_en) begin
            g = -1;
            for (int i = 0; i < lq_pkg::lq_size; i++) begin
                if (rd_gnt[i]) begin
                    g = i;
                end
            end
            check_value("rd_gnt_nonzero", 1, g >= 0);
            if (g >= 0) begin
                check_value("rd_addr_known", 1, m_busy[g] && m_state[g] == lq_pkg::st_ready);
                check_value("rd_tag", m_addr[g][lq_pkg::addr_w-1 -: lq_pkg::tag_w], rd_tag);
                check_value("rd_set", m_addr[g][lq_pkg::offset_w +: lq_pkg::set_w], rd_set);
                check_value("rd_offset", m_addr[g][lq_pkg::offset_w-1:0], rd_offset);
                check_value("rd_size", m_size[g], rd_size);
                if (dc_hit) begin
                    m_data[g] = dc_data;
                    m_state[g] = lq_pkg::st_done;
                end else begin
                    m_state[g] = lq_pkg::st_miss;
                    m_mem_at[g] = cycles + int'($urandom_range(6, 1));
                end
            end
        end

        // one memory reply per cycle as mem_data is shared
        found = 1'b0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (!found && m_busy[i] && m_state[i] == lq_pkg::st_miss
                    && m_mem_at[i] <= cycles) begin
                mem_feedback[i] = 1'b1;
                m_data[i] = mem_data;
                m_state[i] = lq_pkg::st_done;
                found = 1'b1;
            end
        end

        alu_way = 0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (alu_way < lq_pkg::ways && m_busy[i] && m_state[i] == lq_pkg::st_wait_addr
                    && m_alu_at[i] <= cycles) begin
                alu_valid[alu_way] = 1'b1;
                alu_is_ls[alu_way] = 1'b1;
                alu_rob_idx[alu_way] = m_rob[i];
                alu_data[alu_way] = m_addr[i];
                m_state[i] = lq_pkg::st_ready;
                alu_way++;
            end
        end
        // spare way carries a non-load result
        if (alu_way < lq_pkg::ways) begin
            r = $urandom();
            alu_valid[alu_way] = r[0];
        end

        if (!do_flush && loads_sent < total_loads && lq_num_free_out != 0) begin
            r = $urandom();
            want = r[lq_pkg::ways-1:0];
            if (loads_sent == total_loads - 1) begin
                want[1] = 1'b0;
            end
            low = -1;
            high = -1;
            for (int i = 0; i < lq_pkg::lq_size; i++) begin
                if (low < 0 && !m_busy[i]) begin
                    low = i;
                end
            end
            for (int i = lq_pkg::lq_size - 1; i >= 0; i--) begin
                if (high < 0 && !m_busy[i] && i != low) begin
                    high = i;
                end
            end
            for (int w = 0; w < lq_pkg::ways; w++) begin
                if (want[w]) begin
                    ent = (w == 0) ? low : high;
                    while (rob_live(next_rob)) begin
                        next_rob++;
                    end
                    r = $urandom();
                    ld_en[w] = 1'b1;
                    ld_size[w] = 2'($urandom_range(2, 0));
                    ld_is_signed[w] = r[0];
                    ld_prf_idx[w] = r[lq_pkg::prf_idx_w:1];
                    ld_rob_idx[w] = next_rob;
                    m_busy[ent] = 1'b1;
                    m_state[ent] = lq_pkg::st_wait_addr;
                    m_rob[ent] = next_rob;
                    m_prf[ent] = ld_prf_idx[w];
                    m_size[ent] = ld_size[w];
                    m_signed[ent] = ld_is_signed[w];
                    m_addr[ent] = r[31 -: lq_pkg::addr_w];
                    m_alu_at[ent] = cycles + 1 + int'($urandom_range(5, 0));
                    next_rob++;
                    loads_sent++;
                end
            end
        end

        if (rel >= 0) begin
            m_busy[rel] = 1'b0;
        end
        if (do_flush) begin
            for (int i = 0; i < lq_pkg::lq_size; i++) begin
                m_busy[i] = 1'b0;
            end
        end
    endtask

    initial begin
        void'($urandom(63));
        rst_n = 1'b0;
        except = 1'b0;
        ld_en = '0;
        ld_size = '0;
        ld_rob_idx = '0;
        ld_prf_idx = '0;
        ld_is_signed = '0;
        alu_valid = '0;
        alu_is_ls = '0;
        alu_rob_idx = '0;
        alu_data = '0;
        dc_hit = 1'b0;
        dc_data = '0;
        mem_feedback = '0;
        mem_data = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            m_busy[i] = 1'b0;
        end

        repeat (3) begin
            @(negedge clock);
            check_value("reset_free_count", lq_pkg::lq_size, lq_num_free_out);
            check_value("reset_rd_en", 0, rd_en);
            check_value("reset_cdb_valid", 0, cdb_valid);
        end
        rst_n = 1'b1;

        while (loads_sent < total_loads || model_has_loads()) begin
            @(negedge clock);
            flush_now = (flushes == 0 && loads_sent >= 100)
                     || (flushes == 1 && loads_sent >= 200);
            if (flush_now) begin
                flushes++;
            end
            run_cycle(flush_now);
        end

        // empty queue after the last broadcast
        @(negedge clock);
        check_value("final_free_count", lq_pkg::lq_size, lq_num_free_out);
        check_value("final_rd_en", 0, rd_en);
        check_value("final_cdb_valid", 0, cdb_valid);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== test/load_queue_checker.sv ====
`timescale 1ns/1ns

module load_queue_checker (
    input logic                         clock,
    input logic                         rst_n,
    input logic                         except,
    input logic                         rd_en,
    input logic [lq_pkg::lq_size-1:0]   rd_gnt,
    input logic                         cdb_valid,
    input logic [lq_pkg::count_w-1:0]   lq_num_free_out
);

    // at most one cache read per cycle
    rd_grant_onehot: assert property (
        @(posedge clock) disable iff (!rst_n)
        $onehot0(rd_gnt) && (rd_en == (rd_gnt != '0))
    ) else $error("cache grant is not one-hot or disagrees with rd_en");

    free_count_bound: assert property (
        @(posedge clock) lq_num_free_out <= lq_pkg::lq_size
    ) else $error("free count is larger than the queue");

    // flush or reset empties every entry
    cdb_quiet_after_flush: assert property (
        @(posedge clock) (!rst_n || except) |=> !cdb_valid
    ) else $error("CDB broadcast right after reset or flush");

endmodule

bind load_queue load_queue_checker lq_assertions (
    .clock           (clock),
    .rst_n           (rst_n),
    .except          (except),
    .rd_en           (rd_en),
    .rd_gnt          (rd_gnt),
    .cdb_valid       (cdb_valid),
    .lq_num_free_out (lq_num_free_out)
);

// ==== logic/load_queue.sv ====
`timescale 1ns/1ns

module load_queue (
    input  logic                                            clock,
    input  logic                                            rst_n,
    input  logic                                            except,
    input  logic [lq_pkg::ways-1:0]                         ld_en,
    input  logic [lq_pkg::ways-1:0][1:0]                    ld_size,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]  ld_rob_idx,
    input  logic [lq_pkg::ways-1:0][lq_pkg::prf_idx_w-1:0]  ld_prf_idx,
    input  logic [lq_pkg::ways-1:0]                         ld_is_signed,
    input  logic [lq_pkg::ways-1:0]                         alu_valid,
    input  logic [lq_pkg::ways-1:0]                         alu_is_ls,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]  alu_rob_idx,
    input  logic [lq_pkg::ways-1:0][lq_pkg::addr_w-1:0]     alu_data,
    input  logic                                            dc_hit,
    input  logic [lq_pkg::data_w-1:0]                       dc_data,
    input  logic [lq_pkg::lq_size-1:0]                      mem_feedback,
    input  logic [lq_pkg::data_w-1:0]                       mem_data,
    output logic                                            rd_en,
    output logic [lq_pkg::lq_size-1:0]                      rd_gnt,
    output logic [lq_pkg::tag_w-1:0]                        rd_tag,
    output logic [lq_pkg::set_w-1:0]                        rd_set,
    output logic [lq_pkg::offset_w-1:0]                     rd_offset,
    output logic [1:0]                                      rd_size,
    output logic                                            cdb_valid,
    output logic [lq_pkg::data_w-1:0]                       cdb_data,
    output logic [lq_pkg::prf_idx_w-1:0]                    cdb_prf_idx,
    output logic [lq_pkg::rob_idx_w-1:0]                    cdb_rob_idx,
    output logic [lq_pkg::count_w-1:0]                      lq_num_free_out
);

    logic [lq_pkg::lq_size-1:0]                         free;
    logic [lq_pkg::lq_size-1:0]                         alloc_en;
    logic [lq_pkg::lq_size-1:0][lq_pkg::way_idx_w-1:0]  alloc_way;
    logic [lq_pkg::lq_size-1:0]                         done;
    logic [lq_pkg::lq_size-1:0][lq_pkg::data_w-1:0]     ent_data;
    logic [lq_pkg::lq_size-1:0][1:0]                    ent_size;
    logic [lq_pkg::lq_size-1:0]                         ent_signed;
    logic [lq_pkg::lq_size-1:0][lq_pkg::prf_idx_w-1:0]  ent_prf_idx;
    logic [lq_pkg::lq_size-1:0][lq_pkg::rob_idx_w-1:0]  ent_rob_idx;
    logic [lq_pkg::lq_size-1:0]                         cdb_gnt;

    lq_alloc alloc (
        .free      (free),
        .ld_en     (ld_en),
        .alloc_en  (alloc_en),
        .alloc_way (alloc_way)
    );

    lq_entries entries (
        .clock           (clock),
        .rst_n           (rst_n),
        .except          (except),
        .alloc_en        (alloc_en),
        .alloc_way       (alloc_way),
        .ld_size         (ld_size),
        .ld_rob_idx      (ld_rob_idx),
        .ld_prf_idx      (ld_prf_idx),
        .ld_is_signed    (ld_is_signed),
        .alu_valid       (alu_valid),
        .alu_is_ls       (alu_is_ls),
        .alu_rob_idx     (alu_rob_idx),
        .alu_data        (alu_data),
        .dc_hit          (dc_hit),
        .dc_data         (dc_data),
        .mem_feedback    (mem_feedback),
        .mem_data        (mem_data),
        .cdb_gnt         (cdb_gnt),
        .free            (free),
        .done            (done),
        .ent_data        (ent_data),
        .ent_size        (ent_size),
        .ent_signed      (ent_signed),
        .ent_prf_idx     (ent_prf_idx),
        .ent_rob_idx     (ent_rob_idx),
        .rd_en           (rd_en),
        .rd_gnt          (rd_gnt),
        .rd_tag          (rd_tag),
        .rd_set          (rd_set),
        .rd_offset       (rd_offset),
        .rd_size         (rd_size),
        .lq_num_free_out (lq_num_free_out)
    );

    lq_writeback writeback (
        .clock       (clock),
        .rst_n       (rst_n),
        .done        (done),
        .ent_data    (ent_data),
        .ent_size    (ent_size),
        .ent_signed  (ent_signed),
        .ent_prf_idx (ent_prf_idx),
        .ent_rob_idx (ent_rob_idx),
        .cdb_gnt     (cdb_gnt),
        .cdb_valid   (cdb_valid),
        .cdb_data    (cdb_data),
        .cdb_prf_idx (cdb_prf_idx),
        .cdb_rob_idx (cdb_rob_idx)
    );

endmodule

// ==== logic/lq_writeback.sv ====
`timescale 1ns/1ns

module lq_writeback (
    input  logic                                                clock,
    input  logic                                                rst_n,
    input  logic [lq_pkg::lq_size-1:0]                          done,
    input  logic [lq_pkg::lq_size-1:0][lq_pkg::data_w-1:0]      ent_data,
    input  logic [lq_pkg::lq_size-1:0][1:0]                     ent_size,
    input  logic [lq_pkg::lq_size-1:0]                          ent_signed,
    input  logic [lq_pkg::lq_size-1:0][lq_pkg::prf_idx_w-1:0]   ent_prf_idx,
    input  logic [lq_pkg::lq_size-1:0][lq_pkg::rob_idx_w-1:0]   ent_rob_idx,
    output logic [lq_pkg::lq_size-1:0]                          cdb_gnt,
    output logic                                                cdb_valid,
    output logic [lq_pkg::data_w-1:0]                           cdb_data,
    output logic [lq_pkg::prf_idx_w-1:0]                        cdb_prf_idx,
    output logic [lq_pkg::rob_idx_w-1:0]                        cdb_rob_idx
);

    logic [lq_pkg::data_w-1:0] sel_data;
    logic [1:0]                sel_size;
    logic                      sel_signed;
    lq_pkg::load_word_u        word;

    lq_rr_arbiter cdb_arb (
        .clock (clock),
        .rst_n (rst_n),
        .req   (done),
        .gnt   (cdb_gnt)
    );

    assign cdb_valid = |cdb_gnt;

    // fields of the granted entry
    always_comb begin
        sel_data = '0;
        sel_size = '0;
        sel_signed = 1'b0;
        cdb_prf_idx = '0;
        cdb_rob_idx = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (cdb_gnt[i]) begin
                sel_data = ent_data[i];
                sel_size = ent_size[i];
                sel_signed = ent_signed[i];
                cdb_prf_idx = ent_prf_idx[i];
                cdb_rob_idx = ent_rob_idx[i];
            end
        end
    end

    assign word = sel_data;

    // fill bit is the top data bit for signed loads, zero otherwise
    always_comb begin
        case (sel_size)
            lq_pkg::size_byte: begin
                cdb_data = {{(lq_pkg::data_w-8){sel_signed & word.bytes[0][7]}},
                            word.bytes[0]};
            end
            lq_pkg::size_half: begin
                cdb_data = {{(lq_pkg::data_w-16){sel_signed & word.halves[0][15]}},
                            word.halves[0]};
            end
            default: begin
                cdb_data = word;
            end
        endcase
    end

endmodule

// ==== logic/lq_entries.sv ====
`timescale 1ns/1ns

module lq_entries (
    input  logic                                                clock,
    input  logic                                                rst_n,
    input  logic                                                except,
    input  logic [lq_pkg::lq_size-1:0]                          alloc_en,
    input  logic [lq_pkg::lq_size-1:0][lq_pkg::way_idx_w-1:0]   alloc_way,
    input  logic [lq_pkg::ways-1:0][1:0]                        ld_size,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]      ld_rob_idx,
    input  logic [lq_pkg::ways-1:0][lq_pkg::prf_idx_w-1:0]      ld_prf_idx,
    input  logic [lq_pkg::ways-1:0]                             ld_is_signed,
    input  logic [lq_pkg::ways-1:0]                             alu_valid,
    input  logic [lq_pkg::ways-1:0]                             alu_is_ls,
    input  logic [lq_pkg::ways-1:0][lq_pkg::rob_idx_w-1:0]      alu_rob_idx,
    input  logic [lq_pkg::ways-1:0][lq_pkg::addr_w-1:0]         alu_data,
    input  logic                                                dc_hit,
    input  logic [lq_pkg::data_w-1:0]                           dc_data,
    input  logic [lq_pkg::lq_size-1:0]                          mem_feedback,
    input  logic [lq_pkg::data_w-1:0]                           mem_data,
    input  logic [lq_pkg::lq_size-1:0]                          cdb_gnt,
    output logic [lq_pkg::lq_size-1:0]                          free,
    output logic [lq_pkg::lq_size-1:0]                          done,
    output logic [lq_pkg::lq_size-1:0][lq_pkg::data_w-1:0]      ent_data,
    output logic [lq_pkg::lq_size-1:0][1:0]                     ent_size,
    output logic [lq_pkg::lq_size-1:0]                          ent_signed,
    output logic [lq_pkg::lq_size-1:0][lq_pkg::prf_idx_w-1:0]   ent_prf_idx,
    output logic [lq_pkg::lq_size-1:0][lq_pkg::rob_idx_w-1:0]   ent_rob_idx,
    output logic                                                rd_en,
    output logic [lq_pkg::lq_size-1:0]                          rd_gnt,
    output logic [lq_pkg::tag_w-1:0]                            rd_tag,
    output logic [lq_pkg::set_w-1:0]                            rd_set,
    output logic [lq_pkg::offset_w-1:0]                         rd_offset,
    output logic [1:0]                                          rd_size,
    output logic [lq_pkg::count_w-1:0]                          lq_num_free_out
);

    logic [lq_pkg::lq_size-1:0][1:0]                state;
    logic [lq_pkg::lq_size-1:0]                     addr_valid;
    logic [lq_pkg::lq_size-1:0][lq_pkg::addr_w-1:0] addr;
    logic [lq_pkg::lq_size-1:0]                     alu_hit;
    logic [lq_pkg::lq_size-1:0][lq_pkg::addr_w-1:0] alu_addr;
    logic [lq_pkg::lq_size-1:0]                     ready;
    logic [lq_pkg::addr_w-1:0]                      rd_addr;
    logic [lq_pkg::count_w-1:0]                     free_cnt;
    logic [lq_pkg::count_w-1:0]                     alloc_cnt;
    logic [lq_pkg::count_w-1:0]                     free_cnt_next;

    // ALU results only fill occupied entries still missing an address
    always_comb begin
        alu_hit = '0;
        alu_addr = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            for (int w = 0; w < lq_pkg::ways; w++) begin
                if (!free[i] && !addr_valid[i] && alu_valid[w] && alu_is_ls[w]
                        && alu_rob_idx[w] == ent_rob_idx[i]) begin
                    alu_hit[i] = 1'b1;
                    alu_addr[i] = alu_data[w];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            ready[i] = state[i] == lq_pkg::st_ready;
            done[i] = state[i] == lq_pkg::st_done;
        end
    end

    lq_rr_arbiter cache_arb (
        .clock (clock),
        .rst_n (rst_n),
        .req   (ready),
        .gnt   (rd_gnt)
    );

    // one-hot grant steers the winner onto the cache port
    always_comb begin
        rd_addr = '0;
        rd_size = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (rd_gnt[i]) begin
                rd_addr = addr[i];
                rd_size = ent_size[i];
            end
        end
    end

    assign rd_en = |rd_gnt;
    assign rd_tag = rd_addr[lq_pkg::addr_w-1 -: lq_pkg::tag_w];
    assign rd_set = rd_addr[lq_pkg::offset_w +: lq_pkg::set_w];
    assign rd_offset = rd_addr[lq_pkg::offset_w-1:0];

    // loads taken in against the single CDB release
    always_comb begin
        alloc_cnt = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            alloc_cnt = alloc_cnt + {{(lq_pkg::count_w-1){1'b0}}, alloc_en[i]};
        end
        free_cnt_next = free_cnt - alloc_cnt + {{(lq_pkg::count_w-1){1'b0}}, |cdb_gnt};
    end

    always_ff @(posedge clock) begin
        if (!rst_n || except) begin
            free <= '1;
            addr_valid <= '0;
            state <= {lq_pkg::lq_size{lq_pkg::st_wait_addr}};
            free_cnt <= lq_pkg::lq_size[lq_pkg::count_w-1:0];
            lq_num_free_out <= lq_pkg::lq_size[lq_pkg::count_w-1:0];
        end else begin
            free_cnt <= free_cnt_next;
            // sender sees zero once a full pair no longer fits
            lq_num_free_out <= (free_cnt_next < lq_pkg::ways) ? '0 : free_cnt_next;
            for (int i = 0; i < lq_pkg::lq_size; i++) begin
                if (alloc_en[i]) begin
                    free[i] <= 1'b0;
                    addr_valid[i] <= 1'b0;
                    state[i] <= lq_pkg::st_wait_addr;
                end else begin
                    if (alu_hit[i]) begin
                        addr_valid[i] <= 1'b1;
                    end
                    case (state[i])
                        lq_pkg::st_wait_addr: begin
                            if (!free[i] && addr_valid[i]) begin
                                state[i] <= lq_pkg::st_ready;
                            end
                        end
                        lq_pkg::st_ready: begin
                            if (rd_gnt[i]) begin
                                state[i] <= dc_hit ? lq_pkg::st_done : lq_pkg::st_miss;
                            end
                        end
                        lq_pkg::st_miss: begin
                            if (mem_feedback[i]) begin
                                state[i] <= lq_pkg::st_done;
                            end
                        end
                        default: begin
                            // broadcast on the CDB releases the entry
                            if (cdb_gnt[i]) begin
                                state[i] <= lq_pkg::st_wait_addr;
                                free[i] <= 1'b1;
                                addr_valid[i] <= 1'b0;
                            end
                        end
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (alloc_en[i]) begin
                ent_size[i] <= ld_size[alloc_way[i]];
                ent_signed[i] <= ld_is_signed[alloc_way[i]];
                ent_prf_idx[i] <= ld_prf_idx[alloc_way[i]];
                ent_rob_idx[i] <= ld_rob_idx[alloc_way[i]];
            end
            if (alu_hit[i]) begin
                addr[i] <= alu_addr[i];
            end
            if (rd_gnt[i] && dc_hit) begin
                ent_data[i] <= dc_data;
            end
            if (state[i] == lq_pkg::st_miss && mem_feedback[i]) begin
                ent_data[i] <= mem_data;
            end
        end
    end

endmodule

// ==== logic/lq_alloc.sv ====
`timescale 1ns/1ns

module lq_alloc (
    input  logic [lq_pkg::lq_size-1:0]                          free,
    input  logic [lq_pkg::ways-1:0]                             ld_en,
    output logic [lq_pkg::lq_size-1:0]                          alloc_en,
    output logic [lq_pkg::lq_size-1:0][lq_pkg::way_idx_w-1:0]   alloc_way
);

    logic [lq_pkg::lq_size-1:0] low_sel;
    logic [lq_pkg::lq_size-1:0] high_sel;
    logic                       low_found;
    logic                       high_found;

    // lowest free entry, then highest free entry other than that one
    always_comb begin
        low_sel = '0;
        high_sel = '0;
        low_found = 1'b0;
        high_found = 1'b0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (!low_found && free[i]) begin
                low_sel[i] = 1'b1;
                low_found = 1'b1;
            end
        end
        for (int i = lq_pkg::lq_size - 1; i >= 0; i--) begin
            if (!high_found && free[i] && !low_sel[i]) begin
                high_sel[i] = 1'b1;
                high_found = 1'b1;
            end
        end
    end

    // way 0 owns the low pick, way 1 the high one, even if way 0 is idle
    always_comb begin
        alloc_en = '0;
        alloc_way = '0;
        for (int i = 0; i < lq_pkg::lq_size; i++) begin
            if (ld_en[0] && low_sel[i]) begin
                alloc_en[i] = 1'b1;
                alloc_way[i] = 1'b0;
            end
            if (ld_en[1] && high_sel[i]) begin
                alloc_en[i] = 1'b1;
                alloc_way[i] = 1'b1;
            end
        end
    end

endmodule

// ==== logic/lq_rr_arbiter.sv ====
`timescale 1ns/1ns

module lq_rr_arbiter (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic [lq_pkg::lq_size-1:0]  req,
    output logic [lq_pkg::lq_size-1:0]  gnt
);

    logic [lq_pkg::lq_idx_w-1:0] last;
    logic [lq_pkg::lq_idx_w-1:0] idx;
    logic [lq_pkg::lq_idx_w-1:0] gnt_idx;
    logic                        found;

    // search starts just past the last winner and wraps around
    always_comb begin
        gnt = '0;
        gnt_idx = last;
        found = 1'b0;
        idx = last;
        for (int i = 1; i <= lq_pkg::lq_size; i++) begin
            idx = last + i[lq_pkg::lq_idx_w-1:0];
            if (!found && req[idx]) begin
                found = 1'b1;
                gnt[idx] = 1'b1;
                gnt_idx = idx;
            end
        end
    end

    // entry 0 has first pick after reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            last <= '1;
        end else if (found) begin
            last <= gnt_idx;
        end
    end

endmodule

// ==== logic/lq_pkg.sv ====
package lq_pkg;

    // queue and issue sizes
    localparam int lq_size = 8;
    localparam int lq_idx_w = 3;
    localparam int ways = 2;
    localparam int way_idx_w = 1;

    // tags carried by each load
    localparam int rob_idx_w = 5;
    localparam int prf_idx_w = 6;

    // address split as tag, set, offset from the top down
    localparam int addr_w = 16;
    localparam int tag_w = 8;
    localparam int set_w = 5;
    localparam int offset_w = 3;

    localparam int data_w = 32;
    localparam int count_w = 4;

    // load size codes
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // entry states
    localparam logic [1:0] st_wait_addr = 2'd0;
    localparam logic [1:0] st_ready = 2'd1;
    localparam logic [1:0] st_miss = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    // one load word seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0] bytes;
        logic [1:0][15:0] halves;
    } load_word_u;

endpackage
